// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ##############################
    // basic types
    // ##############################

    typedef logic [31:0] u32_t;
    typedef logic [1:0]  mat_t;                  // bit 0 set means cached
    typedef logic [5:0]  ecode_t;

    localparam int   PAGE_OFFSET_W = 12;         // 4 KiB pages only
    localparam mat_t MAT_CC        = 2'b01;      // coherent cached

    // loongarch exception codes
    localparam ecode_t ECODE_ADEF = 6'h08;       // ade, subcode 0 for fetch
    localparam ecode_t ECODE_TLBR = 6'h3f;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PPI  = 6'h07;

    typedef enum logic [2:0] {
        IC_NOP = 3'd0,
        IC_R   = 3'd1
    } ic_op_t;

    // ##############################
    // csr and tlb
    // ##############################

    typedef struct packed {
        logic       da;                          // direct address mode
        logic [1:0] plv;                         // current privilege level
        logic [9:0] asid;
    } csr_t;

    typedef struct packed {
        logic        e;                          // entry exists
        logic [9:0]  asid;
        logic        g;                          // global, ignores asid
        logic [19:0] vppn;
        logic [19:0] ppn;
        logic        v;
        logic [1:0]  plv;
        mat_t        mat;
    } tlb_entry_t;

    // ##############################
    // pipeline records
    // ##############################

    typedef struct packed {
        logic valid;
        u32_t pc;
        logic is_predict;                        // only meaningful from fetch2
    } wr_pc_req_t;

    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    typedef struct packed {
        logic valid;
        u32_t pc;                                // branch pc
        u32_t target;
    } btb_update_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        logic icache_req;
        u32_t next_pc;
        logic next_is_predict;
    } fetch1_fetch2_pass_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        u32_t   badv;                            // faulting virtual address
    } excp_pass_t;

endpackage

`default_nettype wire

// File: design/branch_target_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_INDEX_W = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    hold_i,
    input  fetch_pkg::u32_t         lookup_pc_i,
    input  fetch_pkg::btb_update_t  update_i,
    output fetch_pkg::btb_predict_t predict_o
);

    import fetch_pkg::*;

    localparam int BTB_DEPTH = 1 << BTB_INDEX_W;

    logic [BTB_DEPTH-1:0]   entry_valid_q;
    u32_t                   branch_pc_q [BTB_DEPTH];
    u32_t                   target_q [BTB_DEPTH];

    logic [BTB_INDEX_W-1:0] lookup_idx;
    logic [BTB_INDEX_W-1:0] update_idx;
    logic                   lookup_hit;

    logic                   predict_valid_q;
    u32_t                   predict_npc_q;

    // ##############################
    // table
    // ##############################

    // word-aligned pcs, so skip the two offset bits
    assign lookup_idx = lookup_pc_i[BTB_INDEX_W+1:2];
    assign update_idx = update_i.pc[BTB_INDEX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid_q <= '0;
        end else if (update_i.valid) begin
            entry_valid_q[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.valid) begin
            branch_pc_q[update_idx] <= update_i.pc;   // full tag, no aliasing
            target_q[update_idx]    <= update_i.target;
        end
    end

    // ##############################
    // lookup
    // ##############################

    // reads the table before any same-cycle update lands
    assign lookup_hit = entry_valid_q[lookup_idx]
                      & (branch_pc_q[lookup_idx] == lookup_pc_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            predict_valid_q <= 1'b0;
        end else if (!hold_i) begin
            predict_valid_q <= lookup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            predict_npc_q <= target_q[lookup_idx];
        end
    end

    assign predict_o.valid = predict_valid_q;
    assign predict_o.npc   = predict_npc_q;

endmodule

`default_nettype wire

// File: design/fetch_addr_trans.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_addr_trans #(
    parameter int TLB_ENTRY_NUM = 8
) (
    input  fetch_pkg::u32_t       va_i,
    input  fetch_pkg::csr_t       csr_i,
    input  fetch_pkg::tlb_entry_t tlb_entries_i [TLB_ENTRY_NUM],

    output fetch_pkg::u32_t       pa_o,
    output fetch_pkg::mat_t       mat_o,
    output fetch_pkg::excp_pass_t excp_o
);

    import fetch_pkg::*;

    localparam int IDX_W = (TLB_ENTRY_NUM > 1) ? $clog2(TLB_ENTRY_NUM) : 1;

    logic [TLB_ENTRY_NUM-1:0] entry_match;
    logic                     tlb_hit;
    logic [IDX_W-1:0]         hit_idx;
    tlb_entry_t               hit_entry;
    logic                     misaligned;

    // ##############################
    // tlb search
    // ##############################

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            entry_match[i] = tlb_entries_i[i].e
                           && (tlb_entries_i[i].vppn == va_i[31:PAGE_OFFSET_W])
                           && (tlb_entries_i[i].g || (tlb_entries_i[i].asid == csr_i.asid));
        end
    end

    // scan downwards so the lowest matching entry is the one left
    always_comb begin
        tlb_hit = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (entry_match[i]) begin
                tlb_hit = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry  = tlb_entries_i[hit_idx];
    assign misaligned = |va_i[1:0];

    // ##############################
    // address and exception
    // ##############################

    always_comb begin
        pa_o  = va_i;                             // direct mode passes va through
        mat_o = MAT_CC;
        if (!csr_i.da && tlb_hit) begin
            pa_o  = {hit_entry.ppn, va_i[PAGE_OFFSET_W-1:0]};
            mat_o = hit_entry.mat;
        end
    end

    always_comb begin
        excp_o.valid = 1'b0;
        excp_o.ecode = '0;
        excp_o.badv  = va_i;
        if (misaligned) begin
            excp_o.valid = 1'b1;
            excp_o.ecode = ECODE_ADEF;
        end else if (!csr_i.da) begin
            // mapped mode, graded miss > invalid > privilege
            if (!tlb_hit) begin
                excp_o.valid = 1'b1;
                excp_o.ecode = ECODE_TLBR;
            end else if (!hit_entry.v) begin
                excp_o.valid = 1'b1;
                excp_o.ecode = ECODE_PIF;
            end else if (csr_i.plv > hit_entry.plv) begin
                excp_o.valid = 1'b1;
                excp_o.ecode = ECODE_PPI;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fetch1_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch1_stage #(
    parameter fetch_pkg::u32_t RESET_PC = 32'h1c00_0000
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // btb side
    output logic                           btb_hold_o,
    output fetch_pkg::u32_t                btb_pc_o,
    input  fetch_pkg::btb_predict_t        btb_predict_i,

    // redirect requests
    input  fetch_pkg::wr_pc_req_t          if2_wr_pc_req_i,
    input  fetch_pkg::wr_pc_req_t          mem1_wr_pc_req_i,
    input  fetch_pkg::wr_pc_req_t          excp_wr_pc_req_i,

    // translation side
    output fetch_pkg::u32_t                fetch_pc_o,
    input  fetch_pkg::u32_t                pa_i,
    input  fetch_pkg::mat_t                mat_i,
    input  fetch_pkg::excp_pass_t          addr_excp_i,

    // icache
    output logic [11:0]                    icache_idx_o,
    output fetch_pkg::ic_op_t              icache_op_o,
    output fetch_pkg::u32_t                icache_pa_o,
    output logic                           icache_is_cached_o,
    input  logic                           icache_ready_i,

    // pipeline control
    input  logic                           flush_i,
    input  logic                           stall_i,
    output logic                           stall_o,
    output fetch_pkg::fetch1_fetch2_pass_t pass_o,
    output fetch_pkg::excp_pass_t          excp_pass_o
);

    import fetch_pkg::*;

    u32_t pc_q;
    u32_t npc;
    logic npc_is_predict;
    logic icache_req;                             // no exception, so fetch
    logic pass_valid;

    // ##############################
    // next pc select
    // ##############################

    always_comb begin
        if (excp_wr_pc_req_i.valid) begin
            npc            = excp_wr_pc_req_i.pc;
            npc_is_predict = 1'b0;
        end else if (mem1_wr_pc_req_i.valid) begin
            npc            = mem1_wr_pc_req_i.pc;
            npc_is_predict = 1'b0;
        end else if (if2_wr_pc_req_i.valid) begin
            npc            = if2_wr_pc_req_i.pc;
            npc_is_predict = if2_wr_pc_req_i.is_predict;
        end else if (btb_predict_i.valid) begin
            npc            = btb_predict_i.npc;   // looked up with last cycle's npc
            npc_is_predict = 1'b1;
        end else begin
            npc            = pc_q + 32'd4;
            npc_is_predict = 1'b1;
        end
    end

    // flush overrides the stall so a redirect always lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!stall_o || flush_i) begin
            pc_q <= npc;
        end
    end

    assign btb_pc_o   = npc;
    assign btb_hold_o = stall_o & ~flush_i;
    assign fetch_pc_o = pc_q;

    // ##############################
    // icache request and stall
    // ##############################

    assign icache_req         = ~addr_excp_i.valid;
    assign icache_op_o        = icache_req ? IC_R : IC_NOP;
    assign icache_idx_o       = pc_q[11:0];
    assign icache_pa_o        = pa_i;
    assign icache_is_cached_o = mat_i[0];

    assign stall_o    = stall_i | (icache_req & ~icache_ready_i);
    assign pass_valid = ~stall_o;

    // outputs to fetch2
    assign pass_o.valid           = pass_valid;
    assign pass_o.pc              = pc_q;
    assign pass_o.icache_req      = icache_req;
    assign pass_o.next_pc         = npc;
    assign pass_o.next_is_predict = npc_is_predict;

    always_comb begin
        excp_pass_o       = addr_excp_i;
        excp_pass_o.valid = addr_excp_i.valid & pass_valid;
    end

endmodule

`default_nettype wire

// File: design/fetch_front_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_front_top #(
    parameter fetch_pkg::u32_t RESET_PC      = 32'h1c00_0000,
    parameter int              BTB_INDEX_W   = 6,
    parameter int              TLB_ENTRY_NUM = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  fetch_pkg::csr_t                csr_i,
    input  fetch_pkg::tlb_entry_t          tlb_entries_i [TLB_ENTRY_NUM],

    input  fetch_pkg::wr_pc_req_t          if2_wr_pc_req_i,
    input  fetch_pkg::wr_pc_req_t          mem1_wr_pc_req_i,
    input  fetch_pkg::wr_pc_req_t          excp_wr_pc_req_i,
    input  fetch_pkg::btb_update_t         btb_update_i,

    output logic [11:0]                    icache_idx_o,
    output fetch_pkg::ic_op_t              icache_op_o,
    output fetch_pkg::u32_t                icache_pa_o,
    output logic                           icache_is_cached_o,
    input  logic                           icache_ready_i,

    input  logic                           flush_i,
    input  logic                           stall_i,
    output logic                           stall_o,
    output fetch_pkg::fetch1_fetch2_pass_t pass_o,
    output fetch_pkg::excp_pass_t          excp_pass_o
);

    import fetch_pkg::*;

    logic         btb_hold;
    u32_t         btb_pc;
    btb_predict_t btb_predict;
    u32_t         fetch_pc;
    u32_t         pa;
    mat_t         mat;
    excp_pass_t   addr_excp;

    // ##############################
    // side units, same cycle
    // ##############################

    branch_target_buffer #(
        .BTB_INDEX_W (BTB_INDEX_W)
    ) i_btb (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold_i      (btb_hold),
        .lookup_pc_i (btb_pc),
        .update_i    (btb_update_i),
        .predict_o   (btb_predict)
    );

    fetch_addr_trans #(
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
    ) i_addr_trans (
        .va_i          (fetch_pc),
        .csr_i         (csr_i),
        .tlb_entries_i (tlb_entries_i),
        .pa_o          (pa),
        .mat_o         (mat),
        .excp_o        (addr_excp)
    );

    fetch1_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch1 (
        .clk                (clk),
        .rst_n              (rst_n),
        .btb_hold_o         (btb_hold),
        .btb_pc_o           (btb_pc),
        .btb_predict_i      (btb_predict),
        .if2_wr_pc_req_i    (if2_wr_pc_req_i),
        .mem1_wr_pc_req_i   (mem1_wr_pc_req_i),
        .excp_wr_pc_req_i   (excp_wr_pc_req_i),
        .fetch_pc_o         (fetch_pc),
        .pa_i               (pa),
        .mat_i              (mat),
        .addr_excp_i        (addr_excp),
        .icache_idx_o       (icache_idx_o),
        .icache_op_o        (icache_op_o),
        .icache_pa_o        (icache_pa_o),
        .icache_is_cached_o (icache_is_cached_o),
        .icache_ready_i     (icache_ready_i),
        .flush_i            (flush_i),
        .stall_i            (stall_i),
        .stall_o            (stall_o),
        .pass_o             (pass_o),
        .excp_pass_o        (excp_pass_o)
    );

endmodule

`default_nettype wire

// File: tb/fetch_ref_model.svh
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// ##############################
// model state
// ##############################

localparam int MODEL_BTB_DEPTH = 1 << BTB_INDEX_W;

u32_t pc_m;                                       // pc after the coming edge
logic btb_valid_m  [MODEL_BTB_DEPTH];
u32_t btb_pc_m     [MODEL_BTB_DEPTH];
u32_t btb_target_m [MODEL_BTB_DEPTH];
logic pred_valid_m;
u32_t pred_npc_m;

typedef struct packed {
    u32_t       pa;
    mat_t       mat;
    excp_pass_t excp;
} trans_result_t;

typedef struct packed {
    u32_t npc;
    logic is_predict;
} npc_result_t;

// ##############################
// reference functions
// ##############################

function automatic trans_result_t ref_translate(input u32_t va, input csr_t csr_in);
    trans_result_t res;
    tlb_entry_t    hit_e;
    logic          found;
    found     = 1'b0;
    hit_e     = '0;
    res       = '0;
    res.pa    = va;
    res.mat   = 2'b01;
    res.excp.badv = va;
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
        if (!found && tlb_entries[i].e && (tlb_entries[i].vppn == va[31:12])
            && (tlb_entries[i].g || (tlb_entries[i].asid == csr_in.asid))) begin
            found = 1'b1;                         // first match has priority
            hit_e = tlb_entries[i];
        end
    end
    if (!csr_in.da && found) begin
        res.pa  = {hit_e.ppn, va[11:0]};
        res.mat = hit_e.mat;
    end
    if (va[1:0] != 2'b00) begin
        res.excp.valid = 1'b1;
        res.excp.ecode = ECODE_ADEF;
    end else if (!csr_in.da) begin
        res.excp.valid = !found || !hit_e.v || (csr_in.plv > hit_e.plv);
        if (!found)                      res.excp.ecode = ECODE_TLBR;
        else if (!hit_e.v)               res.excp.ecode = ECODE_PIF;
        else if (csr_in.plv > hit_e.plv) res.excp.ecode = ECODE_PPI;
    end
    return res;
endfunction

function automatic npc_result_t ref_next_pc(input wr_pc_req_t ex_req, input wr_pc_req_t mem_req,
                                            input wr_pc_req_t if2_req, input logic pred_v,
                                            input u32_t pred_npc, input u32_t pc);
    npc_result_t res;
    if (ex_req.valid)        res = '{npc: ex_req.pc, is_predict: 1'b0};
    else if (mem_req.valid)  res = '{npc: mem_req.pc, is_predict: 1'b0};
    else if (if2_req.valid)  res = '{npc: if2_req.pc, is_predict: if2_req.is_predict};
    else if (pred_v)         res = '{npc: pred_npc, is_predict: 1'b1};
    else                     res = '{npc: pc + 32'd4, is_predict: 1'b1};
    return res;
endfunction

task automatic model_reset();
    pc_m         = RESET_PC;
    pred_valid_m = 1'b0;
    pred_npc_m   = '0;
    for (int i = 0; i < MODEL_BTB_DEPTH; i++) begin
        btb_valid_m[i] = 1'b0;
    end
endtask

// one clock edge of pc register and btb
task automatic model_advance(input u32_t npc, input logic stall, input logic flush_in,
                             input btb_update_t upd);
    logic [BTB_INDEX_W-1:0] idx;
    logic [BTB_INDEX_W-1:0] upd_idx;
    idx     = npc[BTB_INDEX_W+1:2];
    upd_idx = upd.pc[BTB_INDEX_W+1:2];
    if (!stall || flush_in) begin
        pred_valid_m = btb_valid_m[idx] && (btb_pc_m[idx] == npc);   // old table content
        pred_npc_m   = btb_target_m[idx];
        pc_m         = npc;
    end
    if (upd.valid) begin
        btb_valid_m[upd_idx]  = 1'b1;
        btb_pc_m[upd_idx]     = upd.pc;
        btb_target_m[upd_idx] = upd.target;
    end
endtask

`endif

// File: tb/tb_fetch_front.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_front;

    import fetch_pkg::*;

    localparam int   CLK_PERIOD    = 8;
    localparam int   RESET_CYCLES  = 8;
    localparam int   BTB_INDEX_W   = 6;
    localparam int   TLB_ENTRY_NUM = 8;
    localparam u32_t RESET_PC      = 32'h1c00_0000;
    localparam int   NUM_PHASES    = 5;           // seq, redirect, btb, tlb, back-pressure
    localparam int   PHASE_CYCLES  = 400;
    localparam int   TOTAL_CYCLES  = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + 8;

    logic                clk = 1'b0;
    logic                rst_n;
    csr_t                csr;
    tlb_entry_t          tlb_entries [TLB_ENTRY_NUM];
    wr_pc_req_t          if2_req;
    wr_pc_req_t          mem1_req;
    wr_pc_req_t          excp_req;
    btb_update_t         btb_update;
    logic [11:0]         icache_idx;
    ic_op_t              icache_op;
    u32_t                icache_pa;
    logic                icache_is_cached;
    logic                icache_ready;
    logic                flush;
    logic                stall_in;
    logic                stall_out;
    fetch1_fetch2_pass_t pass;
    excp_pass_t          excp_pass;

    `include "fetch_ref_model.svh"

    fetch_front_top #(
        .RESET_PC      (RESET_PC),
        .BTB_INDEX_W   (BTB_INDEX_W),
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
    ) i_fetch_front_top (
        .clk (clk), .rst_n (rst_n), .csr_i (csr), .tlb_entries_i (tlb_entries),
        .if2_wr_pc_req_i (if2_req), .mem1_wr_pc_req_i (mem1_req),
        .excp_wr_pc_req_i (excp_req), .btb_update_i (btb_update),
        .icache_idx_o (icache_idx), .icache_op_o (icache_op), .icache_pa_o (icache_pa),
        .icache_is_cached_o (icache_is_cached), .icache_ready_i (icache_ready),
        .flush_i (flush), .stall_i (stall_in), .stall_o (stall_out),
        .pass_o (pass), .excp_pass_o (excp_pass)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##############################
    // stimulus
    // ##############################

    // word addresses in pages 1c000..1c007, pages without a tlb entry give misses
    function automatic u32_t pick_pc(input logic allow_misalign);
        logic [31:0] r;
        u32_t        pc;
        r  = $urandom;
        pc = {20'h1c000 | {17'd0, r[2:0]}, 2'b00, r[10:3], 2'b00};
        if (allow_misalign && r[15:12] == 4'd0) pc[1:0] = r[17:16] | 2'b01;
        return pc;
    endfunction

    task automatic randomize_translation();
        logic [31:0] r;
        tlb_entry_t  e;
        r = $urandom;
        csr <= '{da: 1'b0, plv: r[1:0], asid: {9'd0, r[2]}};
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            r = $urandom;
            e = '{e: r[0] | r[1], asid: {9'd0, r[2]}, g: r[3], vppn: 20'h1c000 | {17'd0, r[6:4]},
                  ppn: r[31:12], v: r[7] | r[8], plv: r[10:9], mat: r[12:11]};
            tlb_entries[i] <= e;
        end
    endtask

    task automatic drive_cycle(input int phase);
        logic [31:0] r;
        wr_pc_req_t  ex_r;
        wr_pc_req_t  mem_r;
        wr_pc_req_t  if2_r;
        btb_update_t upd;
        logic        fl;
        r     = $urandom;
        ex_r  = '{valid: phase >= 1 && r[3:0] == 4'd0, pc: pick_pc(phase >= 3), is_predict: r[27]};
        mem_r = '{valid: phase >= 1 && r[6:4] == 3'd0, pc: pick_pc(phase >= 3), is_predict: r[28]};
        if2_r = '{valid: phase >= 1 && r[9:7] == 3'd0, pc: pick_pc(1'b0), is_predict: r[10]};
        // branch two words ahead of the model pc, so the lookup soon meets it
        upd   = '{valid: phase >= 2 && r[12:11] == 2'b00, pc: pc_m + 32'd8, target: pick_pc(1'b0)};
        fl    = (phase == 4) && r[26:24] == 3'd0;
        if (fl) mem_r.valid = 1'b1;               // flush comes with a redirect
        excp_req     <= ex_r;
        mem1_req     <= mem_r;
        if2_req      <= if2_r;
        btb_update   <= upd;
        flush        <= fl;
        stall_in     <= (phase == 4) && r[21:19] == 3'd0;
        icache_ready <= !((phase == 4) && r[23:22] == 2'b00);
    endtask

    initial begin
        void'($urandom(13566));
        rst_n        <= 1'b0;
        csr          <= '{da: 1'b1, plv: 2'd0, asid: 10'd0};
        if2_req      <= '0;
        mem1_req     <= '0;
        excp_req     <= '0;
        btb_update   <= '0;
        icache_ready <= 1'b1;
        flush        <= 1'b0;
        stall_in     <= 1'b0;
        for (int i = 0; i < TLB_ENTRY_NUM; i++) tlb_entries[i] <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int phase = 0; phase < NUM_PHASES; phase++) begin
            for (int c = 0; c < PHASE_CYCLES; c++) begin
                @(posedge clk);
                if (phase >= 3 && c % 64 == 0) randomize_translation();
                drive_cycle(phase);
            end
        end
        repeat (4) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

    // ##############################
    // compare and watchdog
    // ##############################

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at first mismatch");
    endtask

    // inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin : compare_outputs
        trans_result_t exp_tr;
        npc_result_t   exp_np;
        logic          exp_req;
        logic          exp_stall;
        if (!rst_n) begin
            model_reset();
        end else begin
            exp_tr    = ref_translate(pc_m, csr);
            exp_np    = ref_next_pc(excp_req, mem1_req, if2_req, pred_valid_m, pred_npc_m, pc_m);
            exp_req   = !exp_tr.excp.valid;
            exp_stall = stall_in | (exp_req & !icache_ready);
            assert (icache_idx == pc_m[11:0] && pass.pc == pc_m)
                else report_mismatch($sformatf("pc %h, expected %h", pass.pc, pc_m));
            assert (icache_op == (exp_req ? IC_R : IC_NOP))
                else report_mismatch($sformatf("cache op %0d at pc %h", icache_op, pc_m));
            if (exp_req) begin
                assert (icache_pa == exp_tr.pa && icache_is_cached == exp_tr.mat[0])
                    else report_mismatch($sformatf("pa %h, expected %h", icache_pa, exp_tr.pa));
            end
            assert (stall_out == exp_stall)
                else report_mismatch($sformatf("stall_o %b, expected %b", stall_out, exp_stall));
            assert (pass.valid == !exp_stall && pass.icache_req == exp_req)
                else report_mismatch("pass-along valid or cache request flag wrong");
            assert (pass.next_pc == exp_np.npc && pass.next_is_predict == exp_np.is_predict)
                else report_mismatch($sformatf("next pc %h/%b, expected %h/%b", pass.next_pc,
                                               pass.next_is_predict, exp_np.npc,
                                               exp_np.is_predict));
            assert (excp_pass.valid == (exp_tr.excp.valid & !exp_stall))
                else report_mismatch("exception valid flag wrong");
            if (exp_tr.excp.valid) begin
                assert (excp_pass.ecode == exp_tr.excp.ecode && excp_pass.badv == pc_m)
                    else report_mismatch($sformatf("ecode %h, expected %h", excp_pass.ecode,
                                                   exp_tr.excp.ecode));
            end
            model_advance(exp_np.npc, exp_stall, flush, btb_update);
        end
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 200);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+tb
design/fetch_pkg.sv
design/branch_target_buffer.sv
design/fetch_addr_trans.sv
design/fetch1_stage.sv
design/fetch_front_top.sv
tb/tb_fetch_front.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_fetch_front -f list.f \
		--Mdir obj_dir -o sim_fetch_front
	./obj_dir/sim_fetch_front

clean:
	rm -rf obj_dir
